//--- src/cart_map_params.svh
`ifndef CART_MAP_PARAMS_SVH
`define CART_MAP_PARAMS_SVH

// Console bus widths
`define CM_ADDR_W 24
`define CM_PA_W 8
`define CM_FEAT_W 8
`define CM_MAPPER_W 3

// Feature bit positions
`define CM_FEAT_SRTC 2
`define CM_FEAT_MSU1 3
`define CM_FEAT_213F 4

// Cartridge memory layout
`define CM_SAVERAM_BASE 24'hE00000
`define CM_MENU_ROM_BASE 24'hC00000
`define CM_MASK_OPEN 24'hFFFFFF

// Peripheral windows in the low bank area
`define CM_MSU_BASE 16'h2000        // 8 registers
`define CM_SRTC_BASE 16'h2800       // 2 registers
`define CM_SNESCMD_PAGE 7'b0010101  // 2A00-2BFF
`define CM_213F_PA 8'h3F

`endif

//--- src/cart_map_pkg.sv
`default_nettype none

`include "cart_map_params.svh"

package cart_map_pkg;

  // Mapper codes, the unnamed ones decode to nothing
  typedef enum logic [`CM_MAPPER_W-1:0] {
    MAP_HIROM = 3'd0,
    MAP_LOROM = 3'd1,
    MAP_MENU  = 3'd7
  } cart_mapper_e;

  typedef enum logic [1:0] {
    FLD_MAPPER,
    FLD_FEATURES,
    FLD_ROM_MASK,
    FLD_SAVERAM_MASK
  } cfg_field_e;

  ////////////////////
  // Port payloads

  typedef struct packed {
    cfg_field_e                 field;
    logic [`CM_ADDR_W-1:0]      data;  // Low bits only for mapper/features
  } cfg_write_t;

  typedef struct packed {
    cart_mapper_e               mapper;
    logic [`CM_FEAT_W-1:0]      features;
    logic [`CM_ADDR_W-1:0]      rom_mask;
    logic [`CM_ADDR_W-1:0]      saveram_mask;
  } map_cfg_t;

  typedef struct packed {
    logic [`CM_ADDR_W-1:0]      addr;
    logic [`CM_PA_W-1:0]        pa;    // B-bus address
  } snes_req_t;

  typedef struct packed {
    logic [`CM_ADDR_W-1:0]      rom_addr;
    logic                       rom_hit;
    logic                       is_rom;
    logic                       is_saveram;
    logic                       is_writable;
    logic                       msu_enable;
    logic                       srtc_enable;
    logic                       r213f_enable;
    logic                       snescmd_enable;
  } map_result_t;

endpackage

`default_nettype wire

//--- src/hs_port.sv
`default_nettype none

module hs_port #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     req,
  input  payload_t data,
  output logic     ack,
  output logic     valid,
  output payload_t payload
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PRESENT,  // Valid to consumer
    ST_HOLD      // Ack high, wait for req low
  } hs_state_e;

  hs_state_e state;
  hs_state_e state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (req) begin
          state_nxt = ST_PRESENT;
        end
      end
      ST_PRESENT: state_nxt = ST_HOLD;
      ST_HOLD: begin
        if (!req) begin
          state_nxt = ST_IDLE;  // Ack drops on this edge
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Latch at the capture edge, stays put through the exchange
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req) begin
      payload <= data;
    end
  end

  assign valid = (state == ST_PRESENT);
  assign ack   = (state == ST_HOLD);

endmodule

`default_nettype wire

//--- src/map_cfg_regs.sv
`default_nettype none

`include "cart_map_params.svh"

module map_cfg_regs
  import cart_map_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       wr_valid,
  input  cfg_write_t wr,
  output map_cfg_t   cfg
);

  ////////////////////
  // Field writes

  // Menu mapper with open masks out of reset, so the
  // boot menu runs before the MCU has set anything up
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg.mapper       <= MAP_MENU;
      cfg.features     <= '0;
      cfg.rom_mask     <= `CM_MASK_OPEN;
      cfg.saveram_mask <= `CM_MASK_OPEN;
    end else if (wr_valid) begin
      case (wr.field)
        FLD_MAPPER: begin
          cfg.mapper <= cart_mapper_e'(wr.data[`CM_MAPPER_W-1:0]);
        end
        FLD_FEATURES: begin
          cfg.features <= wr.data[`CM_FEAT_W-1:0];
        end
        FLD_ROM_MASK: begin
          cfg.rom_mask <= wr.data;
        end
        FLD_SAVERAM_MASK: begin
          cfg.saveram_mask <= wr.data;  // Bit 0 clear disables save RAM
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/addr_decode.sv
`default_nettype none

`include "cart_map_params.svh"

module addr_decode
  import cart_map_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        req_valid,
  input  snes_req_t   req,
  input  map_cfg_t    cfg,
  output map_result_t result
);

  logic [`CM_ADDR_W-1:0] a;
  logic                  is_rom;
  logic                  sav_hirom;
  logic                  sav_lorom;
  logic                  sav_menu;
  logic                  is_saveram;
  logic [`CM_ADDR_W-1:0] hi_sram_off;
  logic [`CM_ADDR_W-1:0] lo_sram_off;
  logic [`CM_ADDR_W-1:0] hi_rom_off;
  logic [`CM_ADDR_W-1:0] lo_rom_off;
  logic [`CM_ADDR_W-1:0] rom_addr;
  map_result_t           res_nxt;

  assign a = req.addr;

  ////////////////////
  // Region classification

  // Upper half banks, or upper 32K of any bank
  assign is_rom = a[22] | a[15];

  // HiROM save RAM at banks 20-3F/A0-BF, 6000-7FFF
  assign sav_hirom = ~a[22] & a[21] & ~a[15] & (&a[14:13]);

  // LoROM save RAM at banks 70-7D/F0-FD
  // Lower 32K only once ROM reaches 32 Mbit
  assign sav_lorom = (&a[22:20])
                     & (a[19:16] < 4'hE)
                     & (~a[15] | ~cfg.rom_mask[21]);

  assign sav_menu = &a[23:16];  // Bank FF

  always_comb begin
    is_saveram = 1'b0;
    if (cfg.saveram_mask[0]) begin
      case (cfg.mapper)
        MAP_HIROM: is_saveram = sav_hirom;
        MAP_LOROM: is_saveram = sav_lorom;
        MAP_MENU:  is_saveram = sav_menu;
        default:   is_saveram = 1'b0;
      endcase
    end
  end

  ////////////////////
  // Address translation

  // Bank bits stacked above the in-window offset
  assign hi_sram_off = {6'b0, a[20:16], a[12:0]} & cfg.saveram_mask;
  assign lo_sram_off = {4'b0, a[20:16], a[14:0]} & cfg.saveram_mask;
  assign hi_rom_off  = {1'b0, a[22:0]} & cfg.rom_mask;
  assign lo_rom_off  = {2'b0, a[22:16], a[14:0]} & cfg.rom_mask;  // Drop A15

  always_comb begin
    case (cfg.mapper)
      MAP_HIROM: begin
        if (is_saveram) begin
          rom_addr = `CM_SAVERAM_BASE + hi_sram_off;
        end else begin
          rom_addr = hi_rom_off;
        end
      end
      MAP_LOROM: begin
        if (is_saveram) begin
          rom_addr = `CM_SAVERAM_BASE + lo_sram_off;
        end else begin
          rom_addr = lo_rom_off;
        end
      end
      MAP_MENU: begin
        if (is_saveram) begin
          rom_addr = a;  // Bank FF lands in the save RAM area as is
        end else begin
          rom_addr = `CM_MENU_ROM_BASE + hi_rom_off;
        end
      end
      default: rom_addr = '0;
    endcase
  end

  ////////////////////
  // Result assembly

  always_comb begin
    res_nxt = '0;
    if (cfg.mapper inside {MAP_HIROM, MAP_LOROM, MAP_MENU}) begin
      res_nxt.is_rom      = is_rom;
      res_nxt.is_saveram  = is_saveram;
      res_nxt.is_writable = is_saveram;
      res_nxt.rom_hit     = is_rom | is_saveram;
      res_nxt.rom_addr    = rom_addr;
    end
    // Peripheral windows in system banks only
    res_nxt.msu_enable = cfg.features[`CM_FEAT_MSU1] & ~a[22]
                         & (a[15:3] == 13'(`CM_MSU_BASE >> 3));
    res_nxt.srtc_enable = cfg.features[`CM_FEAT_SRTC] & ~a[22]
                          & (a[15:1] == 15'(`CM_SRTC_BASE >> 1));
    res_nxt.r213f_enable = cfg.features[`CM_FEAT_213F] & (req.pa == `CM_213F_PA);
    res_nxt.snescmd_enable = ~a[22] & (a[15:9] == `CM_SNESCMD_PAGE);
  end

  // Held until the next translation
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else if (req_valid) begin
      result <= res_nxt;
    end
  end

endmodule

`default_nettype wire

//--- src/cart_map_top.sv
`default_nettype none

module cart_map_top
  import cart_map_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  // MCU configuration port
  input  logic        cfg_req,
  input  cfg_write_t  cfg_data,
  output logic        cfg_ack,
  // Console translation port
  input  logic        bus_req,
  input  snes_req_t   bus_data,
  output logic        bus_ack,
  output map_result_t result
);

  logic       cfg_valid;
  cfg_write_t cfg_wr;
  logic       bus_valid;
  snes_req_t  bus_cmd;
  map_cfg_t   map_cfg;

  ////////////////////
  // Handshake ports

  hs_port #(
    .payload_t (cfg_write_t)
  ) i_cfg_port (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (cfg_req),
    .data    (cfg_data),
    .ack     (cfg_ack),
    .valid   (cfg_valid),
    .payload (cfg_wr)
  );

  hs_port #(
    .payload_t (snes_req_t)
  ) i_bus_port (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (bus_req),
    .data    (bus_data),
    .ack     (bus_ack),
    .valid   (bus_valid),
    .payload (bus_cmd)
  );

  ////////////////////
  // Config and decode

  map_cfg_regs i_map_cfg_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .wr_valid (cfg_valid),
    .wr       (cfg_wr),
    .cfg      (map_cfg)
  );

  addr_decode i_addr_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (bus_valid),
    .req       (bus_cmd),
    .cfg       (map_cfg),   // Settled writes apply to this request
    .result    (result)
  );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic arst_n
);

  localparam int HALF_PERIOD = 20;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Held for three rising edges, released just after the third
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    #2 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/cart_map_checker.sv
`default_nettype none

module cart_map_checker
  import cart_map_pkg::*;
(
  input logic        clk,
  input logic        arst_n,
  input logic        bus_req,
  input logic        bus_ack,
  input map_result_t result
);

  int fail_cnt = 0;

  // Req must have been high at the edge that raised ack
  ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(bus_ack) |-> $past(bus_req))
    else begin
      fail_cnt++;
      $error("bus_ack rose while bus_req was low");
    end

  // Ack may only drop once req was seen low
  ack_drop_after_req: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(bus_ack) |-> !$past(bus_req))
    else begin
      fail_cnt++;
      $error("bus_ack fell while bus_req was still high");
    end

  result_on_ack: assert property (@(posedge clk) disable iff (!arst_n)
      !$stable(result) |-> $rose(bus_ack))
    else begin
      fail_cnt++;
      $error("result changed away from the bus_ack rising edge");
    end

endmodule

`default_nettype wire

//--- bench/cart_map_tb.sv
`default_nettype none

`include "cart_map_params.svh"

module cart_map_tb
  import cart_map_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int DRV_DLY = 2;
  localparam int RAND_SEED = 81742;
  localparam int NUM_TESTS = 5;
  localparam int TEST_CYCLES = 250;  // Longest test needs about 130
  localparam int WATCHDOG_TIME = (NUM_TESTS * TEST_CYCLES + 20) * CLK_PERIOD;

  logic        clk;
  logic        arst_n;
  logic        cfg_req;
  cfg_write_t  cfg_data;
  logic        cfg_ack;
  logic        bus_req;
  snes_req_t   bus_data;
  logic        bus_ack;
  map_result_t result;
  map_cfg_t    model_cfg;  // Mirror of the DUT registers
  map_result_t exp_res;
  int          checks = 0;
  int          errors = 0;

  tb_clock i_tb_clock (.clk(clk), .arst_n(arst_n));

  cart_map_top i_cart_map_top (.*);

  bind cart_map_top cart_map_checker i_cart_map_checker (.*);

  ////////////////////
  // Reference model

  function automatic map_result_t expected_result(input snes_req_t r, input map_cfg_t c);
    map_result_t e;
    logic [23:0] a;
    logic        sav;
    logic        known;
    e = '0;
    a = r.addr;
    known = 1'b1;
    sav = 1'b0;
    case (c.mapper)
      MAP_HIROM: begin
        sav = c.saveram_mask[0] && !a[22] && a[21] && !a[15] && a[14] && a[13];
        e.rom_addr = sav ? `CM_SAVERAM_BASE + ({6'd0, a[20:16], a[12:0]} & c.saveram_mask)
                         : {1'b0, a[22:0]} & c.rom_mask;
      end
      MAP_LOROM: begin
        sav = c.saveram_mask[0] && (a[22:20] == 3'b111) && (a[19:16] <= 4'hD)
              && (!a[15] || !c.rom_mask[21]);
        e.rom_addr = sav ? `CM_SAVERAM_BASE + ({4'd0, a[20:16], a[14:0]} & c.saveram_mask)
                         : {2'd0, a[22:16], a[14:0]} & c.rom_mask;
      end
      MAP_MENU: begin
        sav = c.saveram_mask[0] && (a[23:16] == 8'hFF);
        e.rom_addr = sav ? a : `CM_MENU_ROM_BASE + ({1'b0, a[22:0]} & c.rom_mask);
      end
      default: known = 1'b0;
    endcase
    if (known) begin
      e.is_rom = a[22] || a[15];
      e.is_saveram = sav;
      e.is_writable = sav;
      e.rom_hit = e.is_rom || sav;
    end
    e.msu_enable = c.features[`CM_FEAT_MSU1] && !a[22] && (a[15:0] >= 16'h2000)
                   && (a[15:0] <= 16'h2007);
    e.srtc_enable = c.features[`CM_FEAT_SRTC] && !a[22] && (a[15:1] == 15'h1400);
    e.r213f_enable = c.features[`CM_FEAT_213F] && (r.pa == 8'h3F);
    e.snescmd_enable = !a[22] && (a[15:0] >= 16'h2A00) && (a[15:0] <= 16'h2BFF);
    return e;
  endfunction

  task automatic check_result(input string name, input map_result_t got,
                              input map_result_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: result %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_ack(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: %h, expected %h", name, got, exp);
    end
  endtask

  ////////////////////
  // Handshake drivers

  task automatic step_cycle();
    @(posedge clk);
    #DRV_DLY;
  endtask

  task automatic update_model(input cfg_field_e field, input logic [23:0] data);
    case (field)
      FLD_MAPPER:   model_cfg.mapper = cart_mapper_e'(data[2:0]);
      FLD_FEATURES: model_cfg.features = data[7:0];
      FLD_ROM_MASK: model_cfg.rom_mask = data;
      default:      model_cfg.saveram_mask = data;
    endcase
  endtask

  task automatic do_cfg_write(input cfg_field_e field, input logic [23:0] data);
    step_cycle();
    cfg_data.field = field;
    cfg_data.data = data;
    cfg_req = 1'b1;
    step_cycle();
    while (!cfg_ack) step_cycle();
    cfg_req = 1'b0;
    update_model(field, data);
    step_cycle();
    while (cfg_ack) step_cycle();
  endtask

  task automatic do_translate(input logic [23:0] addr, input logic [7:0] pa,
                              output map_result_t res);
    step_cycle();
    bus_data.addr = addr;
    bus_data.pa = pa;
    bus_req = 1'b1;
    step_cycle();
    while (!bus_ack) step_cycle();
    res = result;
    bus_req = 1'b0;
    step_cycle();
    while (bus_ack) step_cycle();
  endtask

  task automatic translate_and_check(input logic [23:0] addr, input logic [7:0] pa);
    map_result_t res;
    snes_req_t   r;
    r.addr = addr;
    r.pa = pa;
    do_translate(addr, pa, res);
    check_result($sformatf("result for %h/%h", addr, pa), res, expected_result(r, model_cfg));
  endtask

  ////////////////////
  // Directed tests

  task automatic test_reset_defaults();
    check_ack("cfg_ack", cfg_ack, 1'b0);
    check_ack("bus_ack", bus_ack, 1'b0);
    check_result("result after reset", result, '0);
    translate_and_check(24'hFF1234, 8'h00);  // Menu save RAM, bank FF
    translate_and_check(24'h008000, 8'h00);
  endtask

  task automatic test_hirom();
    do_cfg_write(FLD_MAPPER, {21'd0, MAP_HIROM});
    do_cfg_write(FLD_SAVERAM_MASK, 24'h001FFF);
    do_cfg_write(FLD_ROM_MASK, 24'h0FFFFF);
    translate_and_check(24'h306000, 8'h00);
    translate_and_check(24'h307ABC, 8'h00);
    translate_and_check(24'hB06010, 8'h00);
    for (int i = 0; i < 8; i++) translate_and_check(24'($urandom), 8'($urandom));
  endtask

  task automatic test_lorom();
    do_cfg_write(FLD_MAPPER, {21'd0, MAP_LOROM});
    do_cfg_write(FLD_SAVERAM_MASK, 24'h007FFF);
    do_cfg_write(FLD_ROM_MASK, 24'h1FFFFF);  // Bit 21 clear, upper half also save RAM
    translate_and_check(24'h700000, 8'h00);
    translate_and_check(24'h708123, 8'h00);
    translate_and_check(24'h7E1234, 8'h00);
    do_cfg_write(FLD_ROM_MASK, 24'h3FFFFF);
    translate_and_check(24'h708123, 8'h00);
    translate_and_check(24'hFD7FFF, 8'h00);
    translate_and_check(24'h7E1234, 8'h00);
    for (int i = 0; i < 8; i++) translate_and_check(24'($urandom), 8'($urandom));
  endtask

  task automatic test_enables();
    logic [7:0] feat;
    do_cfg_write(FLD_MAPPER, {21'd0, MAP_HIROM});
    for (int i = 0; i < 4; i++) begin
      case (i)
        1:       feat = 8'd1 << `CM_FEAT_SRTC;
        2:       feat = 8'd1 << `CM_FEAT_MSU1;
        3:       feat = 8'd1 << `CM_FEAT_213F;
        default: feat = 8'd0;
      endcase
      do_cfg_write(FLD_FEATURES, {16'd0, feat});
      translate_and_check(24'h002000, 8'h3F);
      translate_and_check(24'h802807, 8'h00);
      translate_and_check(24'h002801, 8'h10);
      translate_and_check(24'h402000, 8'h3F);  // Bit 22 set, no window
    end
    translate_and_check(24'h002A00, 8'h00);
    translate_and_check(24'h402A00, 8'h00);
    do_cfg_write(FLD_MAPPER, 24'd4);  // Unnamed code
    translate_and_check(24'h306000, 8'h00);
    translate_and_check(24'hC08000, 8'h00);
  endtask

  task automatic test_handshake();
    do_cfg_write(FLD_MAPPER, {21'd0, MAP_LOROM});
    step_cycle();
    bus_data.addr = 24'h008000;
    bus_data.pa = 8'h00;
    bus_req = 1'b1;
    exp_res = expected_result(bus_data, model_cfg);
    step_cycle();
    check_ack("bus_ack at first edge", bus_ack, 1'b0);
    step_cycle();
    check_ack("bus_ack at second edge", bus_ack, 1'b1);
    check_result("result at second edge", result, exp_res);
    // Changed data under a held request must not be taken
    bus_data.addr = 24'hC12345;
    repeat (4) begin
      step_cycle();
      check_ack("bus_ack while req held", bus_ack, 1'b1);
      check_result("result while req held", result, exp_res);
    end
    bus_req = 1'b0;
    step_cycle();
    check_ack("bus_ack after req low", bus_ack, 1'b0);
    check_result("result after req low", result, exp_res);
    // Mapper switch lands just before the capture edge
    step_cycle();
    cfg_data.field = FLD_MAPPER;
    cfg_data.data = {21'd0, MAP_HIROM};
    cfg_req = 1'b1;
    step_cycle();
    while (!cfg_ack) step_cycle();
    update_model(FLD_MAPPER, {21'd0, MAP_HIROM});
    cfg_req = 1'b0;
    bus_data.addr = 24'h306000;
    bus_req = 1'b1;
    exp_res = expected_result(bus_data, model_cfg);
    step_cycle();
    while (!bus_ack) step_cycle();
    check_result("result after late config", result, exp_res);
    bus_req = 1'b0;
    step_cycle();
    while (bus_ack || cfg_ack) step_cycle();
  endtask

  ////////////////////
  // Run control

  initial begin
    int total;
    cfg_req = 1'b0;
    cfg_data = '0;
    bus_req = 1'b0;
    bus_data = '0;
    model_cfg.mapper = MAP_MENU;
    model_cfg.features = '0;
    model_cfg.rom_mask = `CM_MASK_OPEN;
    model_cfg.saveram_mask = `CM_MASK_OPEN;
    void'($urandom(RAND_SEED));
    wait (arst_n === 1'b1);
    step_cycle();
    test_reset_defaults();
    test_hirom();
    test_lorom();
    test_enables();
    test_handshake();
    total = errors + i_cart_map_top.i_cart_map_checker.fail_cnt;
    $display("Checks: %0d, compare errors: %0d, assertion failures: %0d", checks, errors,
             i_cart_map_top.i_cart_map_checker.fail_cnt);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #WATCHDOG_TIME;
    $display("Timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+src
src/cart_map_pkg.sv
src/hs_port.sv
src/map_cfg_regs.sv
src/addr_decode.sv
src/cart_map_top.sv
bench/tb_clock.sv
bench/cart_map_checker.sv
bench/cart_map_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cart_map_tb -f all.f \
  -o cart_map_sim || exit 1
out=$(./obj_dir/cart_map_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "No errors" && echo "PASS" || { echo "FAIL"; exit 1; }
